/* Bender.yml */
package:
  name: cu_setup

sources:
  - files:
      - verilog/cu_setup_pkg.sv
      - verilog/setup_descriptor_decode.sv
      - verilog/setup_read_sequencer.sv
      - verilog/packet_fifo.sv
      - verilog/cu_setup.sv
  - target: test
    files:
      - testbench/cu_setup_tb.sv

/* project.f */
verilog/cu_setup_pkg.sv
verilog/setup_descriptor_decode.sv
verilog/setup_read_sequencer.sv
verilog/packet_fifo.sv
verilog/cu_setup.sv
testbench/cu_setup_tb.sv

/* testbench/cu_setup_tb.sv */
// Testbench for the compute unit setup unit
// Random descriptors, pops and responses checked against a queue model

`timescale 1ns/10ps

module cu_setup_tb import cu_setup_pkg::*; ();

    localparam int SEED        = 71;
    localparam int NUM_JOBS    = 8;
    localparam int HOLD_CYCLES = 60;
    localparam int RESET_LEN   = 16;
    // Keeps the response queue well below its threshold
    localparam int RSP_LIMIT   = 12;

    logic               ap_clk = 1'b0;
    logic               areset;
    kernel_descriptor_t descriptor_in;
    mem_packet_t        response_in;
    logic               request_pop;
    logic               response_pop;
    mem_packet_t        request_out;
    mem_packet_t        response_out;
    fifo_status_t       request_status;
    fifo_status_t       response_status;
    logic               setup_done;
    logic               fifo_setup_signal;

    logic [ADDR_W-1:0]  exp_addr_q[$];
    mem_payload_t       exp_rsp_q[$];
    logic [DATA_W-1:0]  job_size [NUM_JOBS];
    int                 cycle_count = 0;
    int                 timeout_limit = 1000000;

    cu_setup #(
        .ID_CU (5)
    ) u_dut (
        .ap_clk            (ap_clk),
        .areset            (areset),
        .descriptor_in     (descriptor_in),
        .response_in       (response_in),
        .request_pop       (request_pop),
        .response_pop      (response_pop),
        .request_out       (request_out),
        .response_out      (response_out),
        .request_status    (request_status),
        .response_status   (response_status),
        .setup_done        (setup_done),
        .fifo_setup_signal (fifo_setup_signal)
    );

    always #4 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s, got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // Per cycle output checks and the next inputs
    // ------------------------------------------------------------------
    task automatic step(input bit pop_allowed, input bit inject);
        mem_payload_t rsp;
        @(negedge ap_clk);
        check_equal(request_status.full, 1'b0, "request queue full");
        check_equal(response_status.full, 1'b0, "response queue full");
        check_equal(response_status.prog_full, 1'b0, "response queue prog_full");
        if (request_out.valid) begin
            check_equal(exp_addr_q.size() != 0, 1'b1, "request beyond predicted count");
            check_equal(request_out.payload.cmd, CMD_MEM_READ, "request cmd");
            check_equal(request_out.payload.buffer, STRUCT_CU_SETUP, "request buffer");
            check_equal(request_out.payload.id_cu, 5, "request id_cu");
            check_equal(request_out.payload.address, exp_addr_q.pop_front(), "request address");
        end
        if (setup_done) begin
            check_equal(exp_addr_q.size(), 0, "requests outstanding at done");
        end
        if (response_out.valid) begin
            check_equal(exp_rsp_q.size() != 0, 1'b1, "unexpected response");
            check_equal(response_out.payload, exp_rsp_q.pop_front(), "response payload");
        end

        request_pop  = pop_allowed ? 1'($urandom_range(0, 1)) : 1'b0;
        response_pop = 1'($urandom_range(0, 1));
        response_in  = '0;
        if (inject && $urandom_range(0, 3) == 0 && exp_rsp_q.size() < RSP_LIMIT) begin
            rsp.cmd     = mem_cmd_t'($urandom_range(0, 1));
            rsp.buffer  = BUFFER_W'($urandom);
            rsp.id_cu   = ID_CU_W'($urandom);
            rsp.address = {$urandom, $urandom};
            rsp.data    = $urandom;
            response_in.valid   = 1'b1;
            response_in.payload = rsp;
            exp_rsp_q.push_back(rsp);
        end
    endtask

    // Issue one descriptor and follow it to done and back to idle
    task automatic run_job(input logic [DATA_W-1:0] size, input int hold);
        logic [ADDR_W-1:0] base;
        int                words;
        base  = {$urandom, $urandom};
        words = int'(size >> 1);
        for (int i = 0; i < words; i++) begin
            exp_addr_q.push_back(base + ADDR_W'(i) * WORD_BYTES);
        end
        step(1'b1, 1'b1);
        descriptor_in.valid        = 1'b1;
        descriptor_in.base_address = base;
        descriptor_in.size         = size;
        for (int i = 0; i < hold; i++) begin
            step(1'b0, 1'b1);
        end
        if (hold > 0) begin
            check_equal(request_status.prog_full, 1'b1, "prog_full after long hold");
        end
        while (!setup_done) begin
            step(1'b1, 1'b1);
        end
        descriptor_in.valid = 1'b0;
        while (setup_done) begin
            step(1'b1, 1'b1);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int total_words;
        void'($urandom(SEED));
        areset        = 1'b1;
        descriptor_in = '0;
        response_in   = '0;
        request_pop   = 1'b0;
        response_pop  = 1'b0;

        // Long hold first and the short sizes last
        job_size[0] = 80;
        for (int i = 1; i < NUM_JOBS - 2; i++) begin
            job_size[i] = $urandom_range(0, 81);
        end
        job_size[NUM_JOBS-2] = 0;
        job_size[NUM_JOBS-1] = 1;
        total_words = 0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            total_words += int'(job_size[i] >> 1);
        end
        timeout_limit = total_words * 4 + NUM_JOBS * 40 + HOLD_CYCLES + RESET_LEN + 200;

        for (int i = 0; i < RESET_LEN; i++) begin
            @(negedge ap_clk);
            if (i >= 3) begin
                check_equal(request_out.valid, 1'b0, "request valid in reset");
                check_equal(response_out.valid, 1'b0, "response valid in reset");
                check_equal(setup_done, 1'b0, "setup_done in reset");
                check_equal(request_status.empty, 1'b1, "request empty in reset");
                check_equal(response_status.empty, 1'b1, "response empty in reset");
                check_equal(fifo_setup_signal, 1'b1, "fifo_setup_signal in reset");
            end
        end
        areset = 1'b0;
        for (int i = 0; i < 5; i++) begin
            step(1'b0, 1'b0);
        end
        check_equal(fifo_setup_signal, 1'b0, "fifo_setup_signal after reset");
        check_equal(setup_done, 1'b0, "setup_done after reset");
        check_equal(request_status.empty, 1'b1, "request empty after reset");
        check_equal(response_status.empty, 1'b1, "response empty after reset");

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(job_size[j], (j == 0) ? HOLD_CYCLES : 0);
        end

        // Drain the responses still in flight
        while (exp_rsp_q.size() != 0) begin
            step(1'b1, 1'b0);
        end
        $display("Test passed");
        $finish;
    end

endmodule : cu_setup_tb

/* verilog/cu_setup.sv */
// Compute unit setup unit
// Decodes the kernel descriptor, issues the serial setup reads into a
// request queue and buffers memory responses in a second queue

`timescale 1ns/10ps

module cu_setup import cu_setup_pkg::*; #(
    parameter int ID_CU = 0
) (
    input  logic               ap_clk,
    input  logic               areset,
    input  kernel_descriptor_t descriptor_in,
    input  mem_packet_t        response_in,
    input  logic               request_pop,
    input  logic               response_pop,
    output mem_packet_t        request_out,
    output mem_packet_t        response_out,
    output fifo_status_t       request_status,
    output fifo_status_t       response_status,
    output logic               setup_done,
    output logic               fifo_setup_signal
);

    logic         areset_cu_setup;
    logic [1:0]   setup_shift;
    logic         request_pop_reg;
    logic         response_pop_reg;
    read_config_t read_config;
    logic         request_push;
    mem_payload_t request_payload;

    // ------------------------------------------------------------------
    // Reset and setup indication
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_cu_setup <= areset;
    end

    // Stays high two cycles past the registered reset
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            setup_shift <= 2'b11;
        end else begin
            setup_shift <= {setup_shift[0], 1'b0};
        end
    end

    assign fifo_setup_signal = setup_shift[1];

    // Pop enables are registered before reaching the queues
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            request_pop_reg  <= 1'b0;
            response_pop_reg <= 1'b0;
        end else begin
            request_pop_reg  <= request_pop;
            response_pop_reg <= response_pop;
        end
    end

    // ------------------------------------------------------------------
    // Decode and sequencer
    // ------------------------------------------------------------------
    setup_descriptor_decode u_decode (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_in   (descriptor_in),
        .config_out      (read_config)
    );

    setup_read_sequencer #(
        .ID_CU (ID_CU)
    ) u_sequencer (
        .ap_clk             (ap_clk),
        .areset_cu_setup    (areset_cu_setup),
        .config_in          (read_config),
        .request_status     (request_status),
        .response_full_soon (response_status.prog_full),
        .push               (request_push),
        .push_payload       (request_payload),
        .setup_done         (setup_done)
    );

    // ------------------------------------------------------------------
    // Request and response queues
    // ------------------------------------------------------------------
    packet_fifo #(
        .payload_t (mem_payload_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (request_push),
        .push_data       (request_payload),
        .pop             (request_pop_reg),
        .pop_data        (request_out.payload),
        .pop_valid       (request_out.valid),
        .status          (request_status)
    );

    // Responses go straight in without back-pressure toward memory
    packet_fifo #(
        .payload_t (mem_payload_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_response_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (response_in.valid),
        .push_data       (response_in.payload),
        .pop             (response_pop_reg),
        .pop_data        (response_out.payload),
        .pop_valid       (response_out.valid),
        .status          (response_status)
    );

endmodule : cu_setup

/* verilog/cu_setup_pkg.sv */
// Compute unit setup package
// Shared widths, queue sizing, memory command codes and the packet
// structs passed between the decoder, sequencer and queues

package cu_setup_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int ADDR_W     = 64;
    localparam int DATA_W     = 32;
    // Read address advances one word per request
    localparam int WORD_BYTES = DATA_W / 8;
    localparam int COUNT_W    = 32;
    localparam int ID_CU_W    = 8;
    localparam int BUFFER_W   = 4;

    // ------------------------------------------------------------------
    // Queue sizing
    // ------------------------------------------------------------------
    localparam int FIFO_DEPTH  = 32;
    // Slack above the threshold absorbs pushes still in flight
    localparam int PROG_THRESH = 16;

    // ------------------------------------------------------------------
    // Command and buffer class codes
    // ------------------------------------------------------------------
    typedef enum logic {
        CMD_MEM_READ  = 1'b0,
        CMD_MEM_WRITE = 1'b1
    } mem_cmd_t;

    // Marks packets that belong to the setup structure
    localparam logic [BUFFER_W-1:0] STRUCT_CU_SETUP = 4'd1;

    // ------------------------------------------------------------------
    // Packets
    // ------------------------------------------------------------------
    // Kernel descriptor from the host
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] base_address;
        logic [DATA_W-1:0] size;
    } kernel_descriptor_t;

    // Memory request or response body
    typedef struct packed {
        mem_cmd_t            cmd;
        logic [BUFFER_W-1:0] buffer;
        logic [ID_CU_W-1:0]  id_cu;
        logic [ADDR_W-1:0]   address;
        logic [DATA_W-1:0]   data;
    } mem_payload_t;

    typedef struct packed {
        logic         valid;
        mem_payload_t payload;
    } mem_packet_t;

    // Decoder to sequencer
    typedef struct packed {
        logic               valid;
        logic [ADDR_W-1:0]  base_address;
        logic [COUNT_W-1:0] word_count;
    } read_config_t;

    // Queue occupancy flags
    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

endpackage : cu_setup_pkg

/* verilog/packet_fifo.sv */
// Synchronous packet queue
// Circular buffer over any payload type, with full, empty and
// programmable-full flags and a registered read with a valid pulse

`timescale 1ns/10ps

module packet_fifo import cu_setup_pkg::*; #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic         ap_clk,
    input  logic         areset_cu_setup,
    input  logic         push,
    input  payload_t     push_data,
    input  logic         pop,
    output payload_t     pop_data,
    output logic         pop_valid,
    output fifo_status_t status
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    // ------------------------------------------------------------------
    // Flags from occupancy
    // ------------------------------------------------------------------
    always_comb begin
        status.empty     = (count == '0);
        status.full      = (count == CNT_W'(DEPTH));
        status.prog_full = (count >= CNT_W'(PROG_THRESH));
    end

    // Push when full and pop when empty are ignored
    assign wr_en = push & ~status.full;
    assign rd_en = pop & ~status.empty;

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
        if (rd_en) begin
            pop_data <= mem[rd_ptr];
        end
    end

endmodule : packet_fifo

/* verilog/setup_descriptor_decode.sv */
// Setup descriptor decoder
// Registers the kernel descriptor and derives the read configuration
// handed to the read sequencer

`timescale 1ns/10ps

module setup_descriptor_decode import cu_setup_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  kernel_descriptor_t descriptor_in,
    output read_config_t       config_out
);

    // ------------------------------------------------------------------
    // Descriptor register
    // ------------------------------------------------------------------
    kernel_descriptor_t descriptor_reg;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_reg.valid <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
        end
    end

    // Descriptor fields
    always_ff @(posedge ap_clk) begin
        descriptor_reg.base_address <= descriptor_in.base_address;
        descriptor_reg.size         <= descriptor_in.size;
    end

    // ------------------------------------------------------------------
    // Read configuration
    // ------------------------------------------------------------------
    always_comb begin
        config_out.valid        = descriptor_reg.valid;
        config_out.base_address = descriptor_reg.base_address;
        // Size counts half words so its lowest bit is dropped
        config_out.word_count   = COUNT_W'({1'b0, descriptor_reg.size[DATA_W-1:1]});
    end

endmodule : setup_descriptor_decode

/* verilog/setup_read_sequencer.sv */
// Setup read sequencer
// Walks the configured buffer one word at a time and pushes a read
// request per word into the request queue, pausing on back-pressure

`timescale 1ns/10ps

module setup_read_sequencer import cu_setup_pkg::*; #(
    parameter int ID_CU = 0
) (
    input  logic         ap_clk,
    input  logic         areset_cu_setup,
    input  read_config_t config_in,
    input  fifo_status_t request_status,
    input  logic         response_full_soon,
    output logic         push,
    output mem_payload_t push_payload,
    output logic         setup_done
);

    typedef enum logic [2:0] {
        SEQ_RESET,
        SEQ_IDLE,
        SEQ_START,
        SEQ_BUSY,
        SEQ_PAUSE,
        SEQ_DONE
    } seq_state_t;

    seq_state_t current_state;
    seq_state_t next_state;

    logic [ADDR_W-1:0]  read_address;
    logic [COUNT_W-1:0] words_left;
    logic               stall;
    logic               all_issued;

    // Either queue close to full holds the sequencer
    assign stall      = request_status.prog_full | response_full_soon;
    assign all_issued = (words_left == '0);

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            current_state <= SEQ_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            SEQ_RESET: begin
                next_state = SEQ_IDLE;
            end
            SEQ_IDLE: begin
                if (config_in.valid) begin
                    next_state = SEQ_START;
                end
            end
            SEQ_START: begin
                next_state = SEQ_BUSY;
            end
            SEQ_BUSY: begin
                // Done only once the last request has left the queue
                if (all_issued && request_status.empty) begin
                    next_state = SEQ_DONE;
                end else if (stall) begin
                    next_state = SEQ_PAUSE;
                end
            end
            SEQ_PAUSE: begin
                if (!stall) begin
                    next_state = SEQ_BUSY;
                end
            end
            SEQ_DONE: begin
                // Held until the host withdraws the descriptor
                if (!config_in.valid) begin
                    next_state = SEQ_IDLE;
                end
            end
            default: begin
                next_state = SEQ_RESET;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Address and word counter
    // ------------------------------------------------------------------
    assign push = (current_state == SEQ_BUSY) && !all_issued && !stall;

    always_ff @(posedge ap_clk) begin
        if (current_state == SEQ_START) begin
            read_address <= config_in.base_address;
            words_left   <= config_in.word_count;
        end else if (push) begin
            read_address <= read_address + ADDR_W'(WORD_BYTES);
            words_left   <= words_left - COUNT_W'(1);
        end
    end

    // Read request for the current word
    always_comb begin
        push_payload.cmd     = CMD_MEM_READ;
        push_payload.buffer  = STRUCT_CU_SETUP;
        push_payload.id_cu   = ID_CU_W'(ID_CU);
        push_payload.address = read_address;
        push_payload.data    = '0;
    end

    assign setup_done = (current_state == SEQ_DONE);

endmodule : setup_read_sequencer
